//--- logic/fpu_config.svh
/*
 * FPU format configuration
 * Field widths and exponent bias of the single-precision encoding
 */
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// Biased exponent field
`define FPU_EXP_BITS  8
// Stored fraction without hidden bit
`define FPU_MANT_BITS 23
// Whole encoded word
`define FPU_WORD_BITS 32
// Exponent bias
`define FPU_BIAS      127

`endif

//--- logic/fpu_format_pkg.sv
/*
 * FPU format package
 * Types for the IEEE single-precision encoding and operand classes,
 * plus the fixed encodings used for special results
 */
`include "fpu_config.svh"

package fpu_format_pkg;

   // Whole encoded float
   typedef logic [`FPU_WORD_BITS-1:0]   fp_word_t;
   // Biased exponent field
   typedef logic [`FPU_EXP_BITS-1:0]    fp_exp_t;
   // Stored fraction
   typedef logic [`FPU_MANT_BITS-1:0]   fp_frac_t;
   // Significand including hidden bit
   typedef logic [`FPU_MANT_BITS:0]     fp_sig_t;

   // Class of one operand
   // Zero exponent counts as zero, so subnormals flush here
   typedef struct packed {
      logic is_zero;
      logic is_inf;
      logic is_nan;
   } fp_class_t;

   // Canonical quiet NaN
   localparam fp_word_t FP_QNAN    = 32'h7FC0_0000;
   // Largest finite magnitude, sign bit clear
   localparam fp_word_t FP_MAX_MAG = 32'h7F7F_FFFF;

endpackage

//--- logic/fpu_ctrl_pkg.sv
/*
 * FPU control package
 * Operation and rounding encodings, flag and request structs,
 * and the partial results passed from the units to the merge stage
 */
`include "fpu_config.svh"

package fpu_ctrl_pkg;

   // Operation select
   typedef enum logic {
      MUL  = 1'b0,
      NMUL = 1'b1
   } fpu_op_t;

   // Rounding mode
   typedef enum logic {
      RNE = 1'b0,
      RTZ = 1'b1
   } fpu_rm_t;

   // Status flags of one result
   typedef struct packed {
      logic of;
      logic uf;
      logic zero;
      logic ix;
      logic iv;
      logic inf;
   } fpu_flags_t;

   // Extended signed exponent
   // Wide enough for the sum plus carries
   typedef logic signed [`FPU_EXP_BITS+1:0] fpu_exp_ext_t;

   // One registered request
   typedef struct packed {
      fpu_format_pkg::fp_word_t operand_a;
      fpu_format_pkg::fp_word_t operand_b;
      fpu_rm_t                  rm;
      fpu_op_t                  op;
      logic                     valid;
   } fpu_req_t;

   // Special-case decision
   typedef struct packed {
      logic                     hit;
      fpu_format_pkg::fp_word_t result;
      logic                     iv;
   } fpu_special_t;

   // Rounded product before the range check
   typedef struct packed {
      logic                     sign;
      fpu_exp_ext_t             exp;
      fpu_format_pkg::fp_sig_t  sig;
      logic                     inexact;
   } fpu_arith_t;

endpackage

//--- logic/fpu_special.sv
/*
 * FPU special-case unit
 * Classifies both operands and picks NaN, signed infinity or signed
 * zero when one of them is not a finite nonzero number
 */
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_special
  (
   input  fpu_ctrl_pkg::fpu_req_t     req,
   output fpu_ctrl_pkg::fpu_special_t special
   );

   fpu_format_pkg::fp_class_t class_a;
   fpu_format_pkg::fp_class_t class_b;
   logic                      sign;
   logic                      any_nan;
   logic                      any_inf;
   logic                      any_zero;

   // Decode exponent and fraction into the class bits
   function automatic fpu_format_pkg::fp_class_t classify(input fpu_format_pkg::fp_word_t w);
      fpu_format_pkg::fp_exp_t   e;
      fpu_format_pkg::fp_frac_t  f;
      fpu_format_pkg::fp_class_t c;
      e = w[`FPU_WORD_BITS-2 -: `FPU_EXP_BITS];
      f = w[`FPU_MANT_BITS-1:0];
      c.is_zero = (e == '0);
      c.is_inf  = (e == '1) && (f == '0);
      c.is_nan  = (e == '1) && (f != '0);
      return c;
   endfunction

   assign class_a = classify(req.operand_a);
   assign class_b = classify(req.operand_b);

   // Product sign, flipped for NMUL
   assign sign = req.operand_a[`FPU_WORD_BITS-1] ^ req.operand_b[`FPU_WORD_BITS-1]
                 ^ (req.op == fpu_ctrl_pkg::NMUL);

   assign any_nan  = class_a.is_nan  | class_b.is_nan;
   assign any_inf  = class_a.is_inf  | class_b.is_inf;
   assign any_zero = class_a.is_zero | class_b.is_zero;

   // Zero times infinity is invalid as well
   assign special.iv  = any_nan | (any_inf & any_zero);
   assign special.hit = any_nan | any_inf | any_zero;

   // Priority is NaN, then infinity, then zero
   always_comb
   begin
      special.result = '0;
      if (special.iv)
      begin
         // NaN keeps the canonical sign
         special.result = fpu_format_pkg::FP_QNAN;
      end
      else if (any_inf)
      begin
         special.result = {sign, {`FPU_EXP_BITS{1'b1}}, {`FPU_MANT_BITS{1'b0}}};
      end
      else if (any_zero)
      begin
         special.result = {sign, {(`FPU_WORD_BITS-1){1'b0}}};
      end
   end

endmodule

//--- logic/fpu_mul_datapath.sv
/*
 * FPU multiply datapath
 * Exponent sum, significand product, one-step normalisation and
 * rounding to 24 bits for finite nonzero operands
 */
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_mul_datapath
  (
   input  fpu_ctrl_pkg::fpu_req_t   req,
   output fpu_ctrl_pkg::fpu_arith_t arith
   );

   ////////////////////////////////////////////////////////////////////////////
   // Operand fields
   ////////////////////////////////////////////////////////////////////////////

   fpu_format_pkg::fp_exp_t  exp_a;
   fpu_format_pkg::fp_exp_t  exp_b;
   fpu_format_pkg::fp_sig_t  sig_a;
   fpu_format_pkg::fp_sig_t  sig_b;

   assign exp_a = req.operand_a[`FPU_WORD_BITS-2 -: `FPU_EXP_BITS];
   assign exp_b = req.operand_b[`FPU_WORD_BITS-2 -: `FPU_EXP_BITS];

   // Hidden bit is always set here
   // Zero exponents are handled by the special unit
   assign sig_a = {1'b1, req.operand_a[`FPU_MANT_BITS-1:0]};
   assign sig_b = {1'b1, req.operand_b[`FPU_MANT_BITS-1:0]};

   ////////////////////////////////////////////////////////////////////////////
   // Product and normalisation
   ////////////////////////////////////////////////////////////////////////////

   logic [2*`FPU_MANT_BITS+1:0]  prod;
   logic [2*`FPU_MANT_BITS+1:0]  prod_norm;
   fpu_ctrl_pkg::fpu_exp_ext_t   exp_sum;
   fpu_ctrl_pkg::fpu_exp_ext_t   exp_norm;

   // 24 x 24 into 48 bits, top bit is at index 47 or 46
   assign prod = sig_a * sig_b;

   // Unbiased sum re-biased once
   assign exp_sum = fpu_ctrl_pkg::fpu_exp_ext_t'(exp_a)
                    + fpu_ctrl_pkg::fpu_exp_ext_t'(exp_b)
                    - fpu_ctrl_pkg::fpu_exp_ext_t'(`FPU_BIAS);

   // Product in [2,4) shifts right by one
   // expressed as keeping the top and bumping the exponent
   assign prod_norm = prod[2*`FPU_MANT_BITS+1] ? prod : (prod << 1);
   assign exp_norm  = exp_sum + fpu_ctrl_pkg::fpu_exp_ext_t'(prod[2*`FPU_MANT_BITS+1]);

   ////////////////////////////////////////////////////////////////////////////
   // Rounding
   ////////////////////////////////////////////////////////////////////////////

   fpu_format_pkg::fp_sig_t  mant;
   logic                     guard;
   logic                     sticky;
   logic                     round_up;
   logic [`FPU_MANT_BITS+1:0] sig_round;

   // Kept significand, guard bit, and OR of the rest
   assign mant   = prod_norm[2*`FPU_MANT_BITS+1 -: `FPU_MANT_BITS+1];
   assign guard  = prod_norm[`FPU_MANT_BITS];
   assign sticky = |prod_norm[`FPU_MANT_BITS-1:0];

   // Nearest even rounds up above half, and at half when lsb is odd
   always_comb
   begin
      round_up = 1'b0;
      if (req.rm == fpu_ctrl_pkg::RNE)
      begin
         round_up = guard & (sticky | mant[0]);
      end
   end

   assign sig_round = {1'b0, mant} + (`FPU_MANT_BITS+2)'(round_up);

   // All-ones significand overflowing to 1.0 x 2
   assign arith.sig = sig_round[`FPU_MANT_BITS+1] ? sig_round[`FPU_MANT_BITS+1:1]
                                                  : sig_round[`FPU_MANT_BITS:0];
   assign arith.exp = exp_norm
                      + fpu_ctrl_pkg::fpu_exp_ext_t'(sig_round[`FPU_MANT_BITS+1]);

   assign arith.inexact = guard | sticky;

   // Same sign rule as the special unit
   assign arith.sign = req.operand_a[`FPU_WORD_BITS-1] ^ req.operand_b[`FPU_WORD_BITS-1]
                       ^ (req.op == fpu_ctrl_pkg::NMUL);

endmodule

//--- logic/fpu_result_merge.sv
/*
 * FPU result merge
 * Selects special or arithmetic path, applies the exponent range
 * rules and forms the final word and flags
 */
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_result_merge
  (
   input  fpu_ctrl_pkg::fpu_special_t special,
   input  fpu_ctrl_pkg::fpu_arith_t   arith,
   input  fpu_ctrl_pkg::fpu_rm_t      rm,
   input  logic                       valid_in,
   output fpu_format_pkg::fp_word_t   result_next,
   output fpu_ctrl_pkg::fpu_flags_t   flags_next,
   output logic                       valid_next
   );

   // Normal biased exponent range
   localparam fpu_ctrl_pkg::fpu_exp_ext_t EXP_MAX = (1 << `FPU_EXP_BITS) - 2;
   localparam fpu_ctrl_pkg::fpu_exp_ext_t EXP_MIN = 1;

   always_comb
   begin
      flags_next = '0;
      if (special.hit)
      begin
         result_next   = special.result;
         flags_next.iv = special.iv;
      end
      else if (arith.exp > EXP_MAX)
      begin
         flags_next.of = 1'b1;
         flags_next.ix = 1'b1;
         // RNE saturates to infinity, RTZ to largest finite
         if (rm == fpu_ctrl_pkg::RNE)
            result_next = {arith.sign, {`FPU_EXP_BITS{1'b1}}, {`FPU_MANT_BITS{1'b0}}};
         else
            result_next = {arith.sign, fpu_format_pkg::FP_MAX_MAG[`FPU_WORD_BITS-2:0]};
      end
      else if (arith.exp < EXP_MIN)
      begin
         // Tiny result flushed to signed zero
         flags_next.uf = 1'b1;
         flags_next.ix = 1'b1;
         result_next   = {arith.sign, {(`FPU_WORD_BITS-1){1'b0}}};
      end
      else
      begin
         flags_next.ix = arith.inexact;
         result_next   = {arith.sign, arith.exp[`FPU_EXP_BITS-1:0],
                          arith.sig[`FPU_MANT_BITS-1:0]};
      end

      // Zero and infinity read back from the packed word
      flags_next.zero = (result_next[`FPU_WORD_BITS-2:0] == '0);
      flags_next.inf  = (result_next[`FPU_WORD_BITS-2 -: `FPU_EXP_BITS] == '1)
                        && (result_next[`FPU_MANT_BITS-1:0] == '0);
   end

   // Only accepted requests produce a result
   assign valid_next = valid_in;

endmodule

//--- logic/fpu.sv
/*
 * Floating point multiply unit
 * Input request register, combinational special/datapath/merge core
 * and a registered result with flags and a valid strobe
 */
`timescale 1ns/1ps

module fpu
  (
   input  logic                     Clk_CI,
   input  logic                     Rst_RBI,
   input  fpu_format_pkg::fp_word_t operand_a,
   input  fpu_format_pkg::fp_word_t operand_b,
   input  fpu_ctrl_pkg::fpu_rm_t    rnd_mode,
   input  fpu_ctrl_pkg::fpu_op_t    op,
   input  logic                     enable,
   input  logic                     stall,
   output fpu_format_pkg::fp_word_t result,
   output fpu_ctrl_pkg::fpu_flags_t flags,
   output logic                     valid
   );

   ////////////////////////////////////////////////////////////////////////////
   // Input register
   ////////////////////////////////////////////////////////////////////////////

   fpu_ctrl_pkg::fpu_req_t  req_q;

   // Enable travels as the request valid bit
   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (~Rst_RBI)
      begin
         req_q <= '0;
      end
      else if (~stall)
      begin
         req_q <= '{operand_a: operand_a, operand_b: operand_b,
                    rm: rnd_mode, op: op, valid: enable};
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Core units
   ////////////////////////////////////////////////////////////////////////////

   fpu_ctrl_pkg::fpu_special_t special;
   fpu_ctrl_pkg::fpu_arith_t   arith;
   fpu_format_pkg::fp_word_t   result_next;
   fpu_ctrl_pkg::fpu_flags_t   flags_next;
   logic                       valid_next;

   // Special cases and the arithmetic path run side by side
   fpu_special u_special (
      .req     ( req_q   ),
      .special ( special )
   );

   fpu_mul_datapath u_datapath (
      .req   ( req_q ),
      .arith ( arith )
   );

   fpu_result_merge u_merge (
      .special     ( special     ),
      .arith       ( arith       ),
      .rm          ( req_q.rm    ),
      .valid_in    ( req_q.valid ),
      .result_next ( result_next ),
      .flags_next  ( flags_next  ),
      .valid_next  ( valid_next  )
   );

   ////////////////////////////////////////////////////////////////////////////
   // Output register
   ////////////////////////////////////////////////////////////////////////////

   // Result and flags hold between valid requests
   // Valid is a single-cycle pulse
   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (~Rst_RBI)
      begin
         result <= '0;
         flags  <= '0;
         valid  <= 1'b0;
      end
      else if (~stall)
      begin
         valid <= valid_next;
         if (valid_next)
         begin
            result <= result_next;
            flags  <= flags_next;
         end
      end
   end

endmodule

//--- test/fpu_assertions.sv
/*
 * FPU assertions
 * Reset, stall and flag consistency properties bound into the top level
 */
`timescale 1ns/1ps

module fpu_assertions
  (
   input logic                     Clk_CI,
   input logic                     Rst_RBI,
   input logic                     stall,
   input logic                     valid,
   input fpu_format_pkg::fp_word_t result,
   input fpu_ctrl_pkg::fpu_flags_t flags
   );

   // Number of failed assertions
   int failures = 0;

   // No result strobe while reset is held
   assert property (@(posedge Clk_CI) !Rst_RBI |-> !valid)
   else
   begin
      $error("valid high during reset");
      failures++;
   end

   // Frozen output stage cannot raise valid
   assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) stall |=> !$rose(valid))
   else
   begin
      $error("valid rose while stalled");
      failures++;
   end

   // Invalid always comes with the canonical NaN
   assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
                    flags.iv |-> result == 32'h7FC0_0000)
   else
   begin
      $error("iv without canonical NaN");
      failures++;
   end

   // Overflow is never exact
   assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) flags.of |-> flags.ix)
   else
   begin
      $error("of without ix");
      failures++;
   end

endmodule

bind fpu fpu_assertions u_assertions (
   .Clk_CI  ( Clk_CI  ),
   .Rst_RBI ( Rst_RBI ),
   .stall   ( stall   ),
   .valid   ( valid   ),
   .result  ( result  ),
   .flags   ( flags   )
);

//--- test/tb_fpu.sv
/*
 * FPU testbench
 * Random and directed multiplies through the two-stage unit, checked
 * in order against a reference model of the rounding and range rules
 */
`timescale 1ns/1ps

module tb_fpu;

   // One expected response
   typedef struct packed {
      fpu_format_pkg::fp_word_t result;
      fpu_ctrl_pkg::fpu_flags_t flags;
   } expect_t;

   logic                     Clk_CI;
   logic                     Rst_RBI;
   fpu_format_pkg::fp_word_t operand_a;
   fpu_format_pkg::fp_word_t operand_b;
   fpu_ctrl_pkg::fpu_rm_t    rnd_mode;
   fpu_ctrl_pkg::fpu_op_t    op;
   logic                     enable;
   logic                     stall;
   fpu_format_pkg::fp_word_t result;
   fpu_ctrl_pkg::fpu_flags_t flags;
   logic                     valid;

   expect_t     exp_q[$];
   logic [31:0] lfsr;
   logic        took;
   int          checks;
   int          errors;

   // Zeros, infinities, NaNs, subnormals and two plain numbers
   logic [31:0] specials [11] = '{32'h0000_0000, 32'h8000_0000, 32'h7F80_0000,
                                  32'hFF80_0000, 32'h7FC0_0000, 32'h7F80_0001,
                                  32'hFFC0_0001, 32'h0000_0001, 32'h8040_0000,
                                  32'h3F80_0000, 32'hC020_0000};

   fpu dut (
      .Clk_CI    ( Clk_CI    ),
      .Rst_RBI   ( Rst_RBI   ),
      .operand_a ( operand_a ),
      .operand_b ( operand_b ),
      .rnd_mode  ( rnd_mode  ),
      .op        ( op        ),
      .enable    ( enable    ),
      .stall     ( stall     ),
      .result    ( result    ),
      .flags     ( flags     ),
      .valid     ( valid     )
   );

   // 8 ns clock
   initial
   begin
      Clk_CI = 1'b0;
      forever #4 Clk_CI = ~Clk_CI;
   end

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return v;
   endfunction

   // Random normal number with exponent in [lo, lo + 2^bits)
   function automatic logic [31:0] rand_float(input int exp_lo, input int exp_bits);
      logic [31:0] s;
      logic [31:0] e;
      logic [31:0] f;
      s = take_bits(1);
      e = exp_lo + take_bits(exp_bits);
      f = take_bits(23);
      return {s[0], e[7:0], f[22:0]};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic expect_t ref_mul(input logic [31:0] a, input logic [31:0] b,
                                       input logic rm, input logic neg);
      expect_t e;
      logic    sign;
      logic    nan_any;
      logic    inf_any;
      logic    zero_any;
      longint  p;
      longint  kept;
      longint  rem;
      longint  half;
      int      ex;
      int      sh;
      e        = '0;
      sign     = a[31] ^ b[31] ^ neg;
      nan_any  = (a[30:23] == 8'hFF && a[22:0] != 0) || (b[30:23] == 8'hFF && b[22:0] != 0);
      inf_any  = (a[30:23] == 8'hFF && a[22:0] == 0) || (b[30:23] == 8'hFF && b[22:0] == 0);
      zero_any = (a[30:23] == 8'h00) || (b[30:23] == 8'h00);
      if (nan_any || (inf_any && zero_any))
      begin
         e.result   = 32'h7FC0_0000;
         e.flags.iv = 1'b1;
         return e;
      end
      if (inf_any || zero_any)
      begin
         e.result     = inf_any ? {sign, 31'h7F80_0000} : {sign, 31'h0};
         e.flags.inf  = inf_any;
         e.flags.zero = !inf_any;
         return e;
      end
      // Exact product, then split into 24 kept bits and a remainder
      p    = longint'({1'b1, a[22:0]}) * longint'({1'b1, b[22:0]});
      sh   = (p >= (longint'(1) << 47)) ? 24 : 23;
      ex   = int'(a[30:23]) + int'(b[30:23]) - 127 + (sh - 23);
      kept = p >> sh;
      rem  = p - (kept << sh);
      half = longint'(1) << (sh - 1);
      if (!rm && (rem > half || (rem == half && kept[0])))
         kept++;
      if (kept == (longint'(1) << 24))
      begin
         kept = kept >> 1;
         ex++;
      end
      if (ex > 254)
      begin
         e.flags.of  = 1'b1;
         e.flags.ix  = 1'b1;
         e.flags.inf = !rm;
         e.result    = rm ? {sign, 31'h7F7F_FFFF} : {sign, 31'h7F80_0000};
      end
      else if (ex < 1)
      begin
         e.flags.uf   = 1'b1;
         e.flags.ix   = 1'b1;
         e.flags.zero = 1'b1;
         e.result     = {sign, 31'h0};
      end
      else
      begin
         e.flags.ix = (rem != 0);
         e.result   = {sign, ex[7:0], kept[22:0]};
      end
      return e;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus and checking
   ////////////////////////////////////////////////////////////////////////////

   task automatic compare_value(input string what, input logic [31:0] got,
                                input logic [31:0] want);
      checks++;
      if (got !== want)
      begin
         $display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
         errors++;
      end
   endtask

   // Drive one cycle on the falling edge
   // Expected result queued only if the request is taken
   task automatic send(input logic [31:0] a, input logic [31:0] b, input logic rm,
                       input logic neg, input logic en, input logic st);
      @(negedge Clk_CI);
      operand_a = a;
      operand_b = b;
      rnd_mode  = fpu_ctrl_pkg::fpu_rm_t'(rm);
      op        = fpu_ctrl_pkg::fpu_op_t'(neg);
      enable    = en;
      stall     = st;
      if (en && !st)
         exp_q.push_back(ref_mul(a, b, rm, neg));
   endtask

   // Idle inputs, wait for outstanding results, print the test line
   task automatic drain(input string name, input int chk0, input int err0);
      int n;
      @(negedge Clk_CI);
      enable = 1'b0;
      stall  = 1'b0;
      n      = 0;
      while (exp_q.size() != 0 && n < 50)
      begin
         @(negedge Clk_CI);
         n++;
      end
      if (exp_q.size() != 0)
      begin
         $display("Timeout: %0d results of test %s never arrived", exp_q.size(), name);
         errors++;
         exp_q.delete();
      end
      $display("test %s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
   endtask

   // Pop one entry per fresh valid pulse
   // Stalled repeats are skipped
   initial
   begin
      expect_t e;
      forever
      begin
         @(posedge Clk_CI);
         took = Rst_RBI && !stall;
         @(negedge Clk_CI);
         if (took && valid)
         begin
            if (exp_q.size() == 0)
            begin
               $display("Unexpected result at %0t ns with no request outstanding", $time);
               errors++;
            end
            else
            begin
               e = exp_q.pop_front();
               compare_value("result", result, e.result);
               compare_value("flags", {26'b0, flags}, {26'b0, e.flags});
            end
         end
      end
   end

   initial
   begin
      int chk0;
      int err0;
      Rst_RBI   = 1'b0;
      operand_a = '0;
      operand_b = '0;
      rnd_mode  = fpu_ctrl_pkg::RNE;
      op        = fpu_ctrl_pkg::MUL;
      enable    = 1'b0;
      stall     = 1'b0;
      lfsr      = 32'd38;
      took      = 1'b0;
      checks    = 0;
      errors    = 0;

      // Outputs cleared in and after reset
      chk0 = checks;
      err0 = errors;
      repeat (16) @(posedge Clk_CI);
      @(negedge Clk_CI);
      compare_value("valid in reset", valid, 0);
      compare_value("result in reset", result, 0);
      compare_value("flags in reset", {26'b0, flags}, 0);
      Rst_RBI = 1'b1;
      @(negedge Clk_CI);
      compare_value("valid after reset", valid, 0);
      compare_value("result after reset", result, 0);
      compare_value("flags after reset", {26'b0, flags}, 0);
      drain("reset", chk0, err0);

      chk0 = checks;
      err0 = errors;
      for (int i = 0; i < 200; i++)
         send(rand_float(64, 7), rand_float(64, 7), i[0], i[1], 1'b1, 1'b0);
      drain("random", chk0, err0);

      chk0 = checks;
      err0 = errors;
      for (int i = 0; i < 11; i++)
         for (int j = 0; j < 11; j++)
            send(specials[i], specials[j], j[0], i[0], 1'b1, 1'b0);
      drain("special", chk0, err0);

      // Large exponents, plus a product that only overflows by rounding
      chk0 = checks;
      err0 = errors;
      for (int i = 0; i < 40; i++)
         send(rand_float(200, 5), rand_float(200, 5), i[0], i[1], 1'b1, 1'b0);
      send(32'h7F7F_FFFE, 32'h3F80_0001, 1'b0, 1'b0, 1'b1, 1'b0);
      send(32'h7F7F_FFFE, 32'h3F80_0001, 1'b1, 1'b1, 1'b1, 1'b0);
      drain("overflow", chk0, err0);

      // Tiny products, then exact ones with ix low
      chk0 = checks;
      err0 = errors;
      for (int i = 0; i < 40; i++)
         send(rand_float(1, 5), rand_float(1, 5), i[0], i[1], 1'b1, 1'b0);
      send(32'h3F80_0000, 32'h4040_0000, 1'b0, 1'b0, 1'b1, 1'b0);
      send(32'h4000_0000, 32'hC000_0000, 1'b1, 1'b1, 1'b1, 1'b0);
      drain("underflow", chk0, err0);

      // Enable mostly high, stall about a quarter of the cycles
      chk0 = checks;
      err0 = errors;
      for (int i = 0; i < 300; i++)
         send(rand_float(64, 7), rand_float(64, 7), take_bits(1) != 0, take_bits(1) != 0,
              take_bits(2) != 0, take_bits(2) == 0);
      drain("stall", chk0, err0);

      errors += dut.u_assertions.failures;
      $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
               dut.u_assertions.failures);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- flist.f
+incdir+logic
logic/fpu_format_pkg.sv
logic/fpu_ctrl_pkg.sv
logic/fpu_special.sv
logic/fpu_mul_datapath.sv
logic/fpu_result_merge.sv
logic/fpu.sv
test/fpu_assertions.sv
test/tb_fpu.sv

//--- Bender.yml
package:
  name: fpu

sources:
  - include_dirs:
      - logic
    files:
      - logic/fpu_format_pkg.sv
      - logic/fpu_ctrl_pkg.sv
      - logic/fpu_special.sv
      - logic/fpu_mul_datapath.sv
      - logic/fpu_result_merge.sv
      - logic/fpu.sv
  - target: test
    files:
      - test/fpu_assertions.sv
      - test/tb_fpu.sv
